// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS ?= --binary --timing -Wno-fatal -j 0
TOP ?= fpAddSubTb
FILELIST ?= vlog.f
OBJDIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out=$$(./$(OBJDIR)/V$(TOP) 2>&1); echo "$$out"; \
	echo "$$out" | grep -q -F '** PASS **'

clean:
	rm -rf $(OBJDIR)

// ==== fpAddPkg.sv ====
package fpAddPkg;

	localparam int expWidth = 5; // Exponent field
	localparam int mantWidth = 10; // Stored fraction
	localparam int sigWidth = mantWidth + 1; // Fraction plus hidden one
	localparam int extWidth = sigWidth + 3; // Room for guard round sticky
	localparam int expMax = (1 << expWidth) - 1; // Infinity exponent code
	localparam int pipeLatency = 3; // Input strobe to result strobe

	typedef enum logic {
		opAdd = 1'b0,
		opSub = 1'b1
	} fpOp;

	typedef struct packed {
		logic sign;
		logic [expWidth-1:0] exp; // Biased by 15
		logic [mantWidth-1:0] mant;
	} fpHalf;

	typedef struct packed {
		logic [sigWidth-1:0] bigSig; // Larger magnitude operand
		logic [extWidth-1:0] smallExt; // Shifted smaller operand with GRS
		logic [expWidth-1:0] bigExp; // Exponent of the result before normalize
		logic signA;
		logic signB; // Already flipped for subtract
		logic effSub; // Magnitudes get subtracted
		logic ctrl; // Opcode bit
		logic maxAB; // B is the larger one
	} alignedOps;

	typedef struct packed {
		logic zeroSum; // Exact zero or underflow
		logic [expWidth:0] normE; // Extra bit for carry
		logic [mantWidth-1:0] normM;
		logic guard;
		logic round;
		logic sticky;
		logic signA;
		logic signB;
		logic ctrl;
		logic maxAB;
	} normSum;

	typedef struct packed {
		fpHalf z;
		logic ovf; // Exponent overflow
	} addResult;

endpackage

// ==== fpAddSubTb.sv ====
`timescale 1ns/1ps

module fpAddSubTb;

	typedef struct packed {
		fpAddPkg::fpHalf a;
		fpAddPkg::fpHalf b;
		fpAddPkg::fpOp op;
		fpAddPkg::fpHalf z; // Hand-computed IEEE result
		logic ovf;
	} vecRow;

	typedef struct packed {
		fpAddPkg::addResult want;
		int sampleCycle; // Cycle that held the strobe
	} pendingOp;

	logic clk;
	logic arstN;
	logic inValid;
	fpAddPkg::fpHalf opA;
	fpAddPkg::fpHalf opB;
	fpAddPkg::fpOp op;
	logic outValid;
	fpAddPkg::addResult res;

	vecRow vecTable[$];
	pendingOp pending[$]; // Scoreboard in issue order
	pendingOp head;
	int cycleCnt = 0;
	logic [31:0] rngState = 32'h9793_c50f;

	fpAddSubTop dut0 (.clk(clk), .arstN(arstN), .inValid(inValid), .opA(opA), .opB(opB),
		.op(op), .outValid(outValid), .res(res));

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	always @(posedge clk) cycleCnt <= cycleCnt + 1;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic failRun(input string why);
		$display("ERROR at %0t: %s", $time, why);
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic checkHalf(input string name, input fpAddPkg::fpHalf expVal,
		input fpAddPkg::fpHalf actVal);
		if (actVal !== expVal) begin
			$display("MISMATCH at %0t: %s expected %h actual %h", $time, name, expVal, actVal);
			failRun("result value differs from the expected value");
		end
	endtask

	task automatic checkFlag(input string name, input logic expVal, input logic actVal);
		if (actVal !== expVal) begin
			$display("MISMATCH at %0t: %s expected %b actual %b", $time, name, expVal, actVal);
			failRun("flag differs from the expected value");
		end
	endtask

	task automatic addRow(input logic [15:0] a, input logic [15:0] b, input fpAddPkg::fpOp o,
		input logic [15:0] z, input logic ovf);
		vecRow row;
		row.a = a;
		row.b = b;
		row.op = o;
		row.z = z;
		row.ovf = ovf;
		vecTable.push_back(row);
	endtask

	task automatic buildTable();
		addRow(16'h3C00, 16'h3C00, fpAddPkg::opAdd, 16'h4000, 1'b0); // 1 + 1
		addRow(16'h4200, 16'h3C00, fpAddPkg::opSub, 16'h4000, 1'b0); // 3 - 1
		addRow(16'h3C00, 16'hC000, fpAddPkg::opAdd, 16'hBC00, 1'b0); // 1 + -2
		addRow(16'h3C00, 16'hC000, fpAddPkg::opSub, 16'h4200, 1'b0); // 1 - -2
		addRow(16'hC000, 16'h3C00, fpAddPkg::opSub, 16'hC200, 1'b0); // -2 - 1
		addRow(16'h3C00, 16'h4000, fpAddPkg::opSub, 16'hBC00, 1'b0); // 1 - 2
		addRow(16'h4000, 16'h3800, fpAddPkg::opAdd, 16'h4100, 1'b0); // 2 + 0.5
		addRow(16'h3C00, 16'h1000, fpAddPkg::opAdd, 16'h3C00, 1'b0); // Half ulp tie, even stays
		addRow(16'h3C01, 16'h1000, fpAddPkg::opAdd, 16'h3C02, 1'b0); // Tie on odd goes up
		addRow(16'h3C00, 16'h1001, fpAddPkg::opAdd, 16'h3C01, 1'b0); // Sticky breaks the tie
		addRow(16'h3BFF, 16'h0C00, fpAddPkg::opAdd, 16'h3C00, 1'b0); // Round carries into exp
		addRow(16'h3C01, 16'h3C00, fpAddPkg::opSub, 16'h1400, 1'b0); // Ten bit left shift
		addRow(16'h4500, 16'h4500, fpAddPkg::opSub, 16'h0000, 1'b0); // x - x
		addRow(16'hC500, 16'hC500, fpAddPkg::opSub, 16'h0000, 1'b0); // -x - -x
		addRow(16'h8000, 16'h8000, fpAddPkg::opAdd, 16'h8000, 1'b0); // -0 + -0
		addRow(16'h0401, 16'h0400, fpAddPkg::opSub, 16'h0000, 1'b0); // Underflow flushes
		addRow(16'h0001, 16'h0000, fpAddPkg::opAdd, 16'h0000, 1'b0); // Subnormal in is zero
		addRow(16'h7BFF, 16'h7BFF, fpAddPkg::opAdd, 16'h7C00, 1'b1); // Max + max
		addRow(16'hFBFF, 16'hFBFF, fpAddPkg::opAdd, 16'hFC00, 1'b1); // Negative overflow
		addRow(16'h7BFF, 16'h4C00, fpAddPkg::opAdd, 16'h7C00, 1'b1); // Tie rounds into inf
		addRow(16'h7A00, 16'h7000, fpAddPkg::opAdd, 16'h7B00, 1'b0); // Large but finite
		addRow(16'h7BFE, 16'h3C00, fpAddPkg::opAdd, 16'h7BFE, 1'b0); // Tiny addend lost
	endtask

	task automatic applyRow(input vecRow row);
		pendingOp entry;
		opA = row.a;
		opB = row.b;
		op = row.op;
		inValid = 1'b1;
		entry.want.z = row.z;
		entry.want.ovf = row.ovf;
		entry.sampleCycle = cycleCnt; // Strobe held until the coming edge
		pending.push_back(entry);
	endtask

	// Outputs settle long before the falling edge
	always @(negedge clk) begin
		if (outValid) begin
			if (pending.size() == 0) begin
				failRun("outValid high with no operation in flight");
			end else begin
				head = pending.pop_front();
				if (cycleCnt - head.sampleCycle != fpAddPkg::pipeLatency) begin
					$display("MISMATCH at %0t: outValid latency expected %0d actual %0d",
						$time, fpAddPkg::pipeLatency, cycleCnt - head.sampleCycle);
					failRun("result strobe at the wrong cycle");
				end
				checkHalf("res.z", head.want.z, res.z);
				checkFlag("res.ovf", head.want.ovf, res.ovf);
			end
		end else if (pending.size() != 0
			&& cycleCnt - pending[0].sampleCycle > fpAddPkg::pipeLatency) begin
			failRun("no result arrived for an issued operation");
		end
	end

	initial begin
		#20000;
		failRun("simulation time limit reached"); // Overall watchdog
	end

	initial begin
		int gap;
		int waitCycles;
		arstN = 1'b0;
		inValid = 1'b0;
		opA = '0;
		opB = '0;
		op = fpAddPkg::opAdd;
		buildTable();
		repeat (10) @(posedge clk);
		#0.5;
		arstN = 1'b1;
		repeat (3) @(posedge clk); // Idle after reset, monitor watches outValid
		#0.5;
		for (int i = 0; i < vecTable.size(); i++) begin
			applyRow(vecTable[i]);
			@(posedge clk);
			#0.5;
			rngState = xorshift(rngState);
			gap = (i < 4) ? 0 : int'(rngState % 32'd4); // First rows back to back
			if (gap != 0) begin
				inValid = 1'b0;
				repeat (gap) @(posedge clk);
				#0.5;
			end
		end
		inValid = 1'b0;
		waitCycles = 0;
		while (pending.size() != 0) begin // Drain the pipe
			@(posedge clk);
			waitCycles++;
			if (waitCycles > 4 * fpAddPkg::pipeLatency) begin
				failRun("pipeline did not drain after the last operation");
			end
		end
		repeat (6) @(posedge clk); // No stray strobes once empty
		$display("** PASS **");
		$finish;
	end

endmodule

// ==== fpAddSubTop.sv ====
`timescale 1ns/1ps

module fpAddSubTop (
	input logic clk,
	input logic arstN,
	input logic inValid,
	input fpAddPkg::fpHalf opA,
	input fpAddPkg::fpHalf opB,
	input fpAddPkg::fpOp op,
	output logic outValid,
	output fpAddPkg::addResult res
);

	logic [fpAddPkg::sigWidth-1:0] bigSig; // Stage 1 comb
	logic [fpAddPkg::sigWidth-1:0] smallSig;
	logic [fpAddPkg::expWidth-1:0] bigExp;
	logic [fpAddPkg::expWidth-1:0] expDiff;
	logic signA;
	logic signB;
	logic effSub;
	logic ctrl;
	logic maxAB;
	fpAddPkg::alignedOps alignedComb;
	fpAddPkg::alignedOps stage1Reg;
	logic [fpAddPkg::extWidth:0] rawSum; // Stage 2 comb
	fpAddPkg::alignedOps passOps;
	fpAddPkg::normSum normComb;
	fpAddPkg::normSum stage2Reg;
	fpAddPkg::addResult roundComb; // Stage 3 comb
	logic [fpAddPkg::pipeLatency-1:0] validPipe; // One bit per stage

	fpPrealign prealign0 (.opA(opA), .opB(opB), .op(op), .bigSig(bigSig),
		.smallSig(smallSig), .bigExp(bigExp), .expDiff(expDiff), .signA(signA),
		.signB(signB), .effSub(effSub), .ctrl(ctrl), .maxAB(maxAB));

	fpAlignShift alignShift0 (.bigSig(bigSig), .smallSig(smallSig), .bigExp(bigExp),
		.expDiff(expDiff), .signA(signA), .signB(signB), .effSub(effSub),
		.ctrl(ctrl), .maxAB(maxAB), .aligned(alignedComb));

	fpMantExecute mantExecute0 (.aligned(stage1Reg), .rawSum(rawSum), .pass(passOps));

	fpNormalize normalize0 (.rawSum(rawSum), .pass(passOps), .norm(normComb));

	fpRoundModule roundModule0 (.norm(stage2Reg), .result(roundComb));

	// Data loads every cycle and validPipe marks live slots
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			validPipe <= '0;
			stage1Reg <= '0;
			stage2Reg <= '0;
			res <= '0;
		end else begin
			validPipe <= {validPipe[fpAddPkg::pipeLatency-2:0], inValid};
			stage1Reg <= alignedComb;
			stage2Reg <= normComb;
			res <= roundComb;
		end
	end

	assign outValid = validPipe[fpAddPkg::pipeLatency-1]; // Lines up with res

endmodule

// ==== fpAlignShift.sv ====
`timescale 1ns/1ps

module fpAlignShift (
	input logic [fpAddPkg::sigWidth-1:0] bigSig,
	input logic [fpAddPkg::sigWidth-1:0] smallSig,
	input logic [fpAddPkg::expWidth-1:0] bigExp,
	input logic [fpAddPkg::expWidth-1:0] expDiff,
	input logic signA,
	input logic signB,
	input logic effSub,
	input logic ctrl,
	input logic maxAB,
	output fpAddPkg::alignedOps aligned
);

	logic [fpAddPkg::extWidth-1:0] smallPad; // Three zero GRS bits appended
	logic [fpAddPkg::extWidth-1:0] shifted;
	logic [fpAddPkg::extWidth-1:0] lostMask; // Bits that fall off the bottom
	logic lostBits;

	assign smallPad = {smallSig, 3'b000};
	assign shifted = smallPad >> expDiff; // Zero once expDiff passes extWidth

	// Everything below the sticky slot collapses into sticky
	// A huge difference gives an all ones mask so only sticky survives
	assign lostMask = ~({fpAddPkg::extWidth{1'b1}} << expDiff);
	assign lostBits = |(smallPad & lostMask);

	always_comb begin
		aligned.bigSig = bigSig;
		aligned.smallExt = {shifted[fpAddPkg::extWidth-1:1], shifted[0] | lostBits};
		aligned.bigExp = bigExp;
		aligned.signA = signA;
		aligned.signB = signB;
		aligned.effSub = effSub;
		aligned.ctrl = ctrl;
		aligned.maxAB = maxAB;
	end

endmodule

// ==== fpMantExecute.sv ====
`timescale 1ns/1ps

module fpMantExecute (
	input fpAddPkg::alignedOps aligned,
	output logic [fpAddPkg::extWidth:0] rawSum,
	output fpAddPkg::alignedOps pass
);

	logic [fpAddPkg::extWidth:0] bigWide; // Carry bit on top
	logic [fpAddPkg::extWidth:0] smallWide;

	// Big side has no GRS content
	assign bigWide = {1'b0, aligned.bigSig, 3'b000};
	assign smallWide = {1'b0, aligned.smallExt};

	// Big operand is never smaller so the difference stays positive
	// Sticky in bit 0 borrows correctly for rounding
	assign rawSum = aligned.effSub ? (bigWide - smallWide) : (bigWide + smallWide);

	// Forward control and exponent to normalize
	always_comb begin
		pass = aligned;
		pass.bigSig = '0; // Consumed here
		pass.smallExt = '0; // Consumed here
	end

endmodule

// ==== fpNormalize.sv ====
`timescale 1ns/1ps

module fpNormalize (
	input logic [fpAddPkg::extWidth:0] rawSum,
	input fpAddPkg::alignedOps pass,
	output fpAddPkg::normSum norm
);

	logic carry; // Sum overflowed into bit extWidth
	logic seenOne;
	logic sumIsZero;
	logic [fpAddPkg::expWidth-1:0] lzc; // 0 to extWidth
	logic [fpAddPkg::extWidth-1:0] body;
	logic [fpAddPkg::extWidth-1:0] leftShifted;
	logic [fpAddPkg::extWidth-1:0] normBits; // Hidden bit on top then fraction then GRS
	logic [fpAddPkg::expWidth+1:0] bigExpWide;
	logic [fpAddPkg::expWidth+1:0] lzcWide;
	logic signed [fpAddPkg::expWidth+1:0] expCalc; // Can go negative on cancellation

	assign carry = rawSum[fpAddPkg::extWidth];
	assign body = rawSum[fpAddPkg::extWidth-1:0];

	// Leading zero count from the top
	always_comb begin
		lzc = '0;
		seenOne = 1'b0;
		for (int i = fpAddPkg::extWidth - 1; i >= 0; i--) begin
			seenOne = seenOne | body[i];
			lzc = lzc + {{(fpAddPkg::expWidth-1){1'b0}}, ~seenOne};
		end
	end

	assign leftShifted = body << lzc; // Zeros enter at sticky

	// Carry case drops bit 0 into sticky
	assign normBits = carry ? {rawSum[fpAddPkg::extWidth:2], rawSum[1] | rawSum[0]}
		: leftShifted;

	assign bigExpWide = {2'b00, pass.bigExp};
	assign lzcWide = {2'b00, lzc};
	assign expCalc = carry ? (bigExpWide + 1'b1) : (bigExpWide - lzcWide);

	// Cancelled to zero or fell into subnormal range
	assign sumIsZero = (rawSum == '0) | (expCalc <= 0);

	always_comb begin
		norm.zeroSum = sumIsZero;
		norm.normE = expCalc[fpAddPkg::expWidth:0]; // Positive whenever not zero
		norm.normM = sumIsZero ? '0
			: normBits[fpAddPkg::extWidth-2 -: fpAddPkg::mantWidth];
		norm.guard = ~sumIsZero & normBits[2]; // No rounding on a flushed result
		norm.round = ~sumIsZero & normBits[1];
		norm.sticky = ~sumIsZero & normBits[0];
		norm.signA = pass.signA;
		norm.signB = pass.signB;
		norm.ctrl = pass.ctrl;
		norm.maxAB = pass.maxAB;
	end

endmodule

// ==== fpPrealign.sv ====
`timescale 1ns/1ps

module fpPrealign (
	input fpAddPkg::fpHalf opA,
	input fpAddPkg::fpHalf opB,
	input fpAddPkg::fpOp op,
	output logic [fpAddPkg::sigWidth-1:0] bigSig,
	output logic [fpAddPkg::sigWidth-1:0] smallSig,
	output logic [fpAddPkg::expWidth-1:0] bigExp,
	output logic [fpAddPkg::expWidth-1:0] expDiff,
	output logic signA,
	output logic signB,
	output logic effSub,
	output logic ctrl,
	output logic maxAB
);

	logic [fpAddPkg::sigWidth-1:0] sigA; // Hidden bit restored
	logic [fpAddPkg::sigWidth-1:0] sigB;
	logic [fpAddPkg::expWidth-1:0] smallExp;
	logic [fpAddPkg::expWidth+fpAddPkg::sigWidth-1:0] magA; // Exponent above significand
	logic [fpAddPkg::expWidth+fpAddPkg::sigWidth-1:0] magB;

	// Zero exponent means zero or subnormal, both flushed
	assign sigA = (opA.exp == '0) ? '0 : {1'b1, opA.mant};
	assign sigB = (opB.exp == '0) ? '0 : {1'b1, opB.mant};

	// Exponent first then significand
	assign magA = {opA.exp, sigA};
	assign magB = {opB.exp, sigB};
	assign maxAB = (magB > magA); // Ties keep A on the big side

	assign ctrl = (op == fpAddPkg::opSub);
	assign signA = opA.sign;
	assign signB = opB.sign ^ ctrl; // Subtract becomes add of negated B
	assign effSub = signA ^ signB; // Opposite signs subtract magnitudes

	// Route larger magnitude to the big side
	assign bigSig = maxAB ? sigB : sigA;
	assign smallSig = maxAB ? sigA : sigB;
	assign bigExp = maxAB ? opB.exp : opA.exp;
	assign smallExp = maxAB ? opA.exp : opB.exp;

	assign expDiff = bigExp - smallExp; // Never negative after ordering

endmodule

// ==== fpRoundModule.sv ====
`timescale 1ns/1ps

module fpRoundModule (
	input fpAddPkg::normSum norm,
	output fpAddPkg::addResult result
);

	logic roundUp; // Nearest even says add one ulp
	logic [fpAddPkg::mantWidth:0] roundUpM; // Extra bit catches fraction wrap
	logic [fpAddPkg::mantWidth-1:0] roundM;
	logic roundOvf; // Fraction wrapped to zero
	logic [fpAddPkg::expWidth:0] roundE;
	logic rawSignB; // B sign as it came in
	logic fSign;
	logic expOvf;

	// Above half or exact tie on an odd fraction
	assign roundUp = norm.guard & (norm.round | norm.sticky | norm.normM[0]);

	assign roundUpM = {1'b0, norm.normM} + 1'b1;
	assign roundM = roundUp ? roundUpM[fpAddPkg::mantWidth-1:0] : norm.normM;
	assign roundOvf = roundUp & roundUpM[fpAddPkg::mantWidth];

	// Wrapped fraction is zero again so only the exponent moves
	assign roundE = norm.zeroSum ? '0
		: (norm.normE + {{fpAddPkg::expWidth{1'b0}}, roundOvf});

	assign rawSignB = norm.signB ^ norm.ctrl; // Undo the opcode flip

	// Zero takes the combined operand rule
	// Otherwise the sign of the larger magnitude wins
	assign fSign = (norm.zeroSum & (norm.signA ^ rawSignB))
		| (norm.zeroSum ? (norm.signA & rawSignB & ~norm.ctrl)
			: ((~norm.maxAB & norm.signA) | (norm.signB & (norm.maxAB | norm.signA))));

	assign expOvf = (roundE >= fpAddPkg::expMax); // Past the largest finite exponent

	always_comb begin
		result.z.sign = fSign;
		result.z.exp = expOvf ? '1 : roundE[fpAddPkg::expWidth-1:0]; // Infinity code
		result.z.mant = expOvf ? '0 : roundM;
		result.ovf = expOvf;
	end

endmodule

// ==== vlog.f ====
fpAddPkg.sv
fpPrealign.sv
fpAlignShift.sv
fpMantExecute.sv
fpNormalize.sv
fpRoundModule.sv
fpAddSubTop.sv
fpAddSubTb.sv
